// File: processor.f
proc_pkg.sv
instr_decoder.sv
alu.sv
forwarding_unit.sv
hazard_unit.sv
execute_stage.sv
processor.sv
processor_tb.sv

// File: Bender.yml
package:
  name: processor

sources:
  - proc_pkg.sv
  - instr_decoder.sv
  - alu.sv
  - forwarding_unit.sv
  - hazard_unit.sv
  - execute_stage.sv
  - processor.sv
  - target: test
    files:
      - processor_tb.sv

// File: processor_tb.sv
// Pipelined core testbench
`timescale 1ns/100ps

module processor_tb import proc_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 80;   // Longest program plus drain
    localparam int NUM_TESTS    = 6;
    localparam int CYCLE_LIMIT  = NUM_TESTS * (TEST_CYCLES + RESET_CYCLES) + 60;
    localparam int DRAIN_CYCLES = 8;

    logic      clock;
    logic      reset;
    word_t     address_imem, q_imem;
    word_t     address_dmem, data, q_dmem;
    logic      wren;
    logic      ctrl_write_enable;
    reg_addr_t ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;
    word_t     data_write_reg, data_read_reg_a, data_read_reg_b;

    word_t imem [256];
    word_t dmem [256];
    word_t regs [32];

    logic [63:0] reg_log [$];   // {reg number, value}
    logic [63:0] mem_log [$];   // {address, value}
    logic [63:0] reg_want [$];
    logic [63:0] mem_want [$];

    int prog_len;
    int halt_pc;
    int cycle_count = 0;
    int checks = 0;
    int errors = 0;
    int errors_at_start;
    int tests_run = 0;

    processor DUT (
        .clock(clock), .reset(reset),
        .address_imem(address_imem), .q_imem(q_imem),
        .address_dmem(address_dmem), .data(data), .wren(wren), .q_dmem(q_dmem),
        .ctrl_write_enable(ctrl_write_enable), .ctrl_write_reg(ctrl_write_reg),
        .ctrl_read_reg_a(ctrl_read_reg_a), .ctrl_read_reg_b(ctrl_read_reg_b),
        .data_write_reg(data_write_reg),
        .data_read_reg_a(data_read_reg_a), .data_read_reg_b(data_read_reg_b)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Memory and register file models
    assign q_imem          = imem[address_imem[7:0]];
    assign q_dmem          = dmem[address_dmem[7:0]];
    assign data_read_reg_a = regs[ctrl_read_reg_a];
    assign data_read_reg_b = regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (!reset && ctrl_write_enable === 1'b1) begin
            reg_log.push_back({27'b0, ctrl_write_reg, data_write_reg});
            if (ctrl_write_reg != '0) begin
                regs[ctrl_write_reg] <= data_write_reg;  // $0 stays zero
            end
        end
        if (!reset && wren === 1'b1) begin
            mem_log.push_back({address_dmem, data});
            dmem[address_dmem[7:0]] <= data;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    function automatic word_t rtype_word(reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
                                         alu_op_t op, shamt_t sh);
        return {OP_RTYPE, rd, rs, rt, sh, op, 2'b00};
    endfunction

    function automatic word_t itype_word(opcode_t opc, reg_addr_t rd, reg_addr_t rs, int imm);
        return {opc, rd, rs, imm[16:0]};
    endfunction

    function automatic word_t jump_word(opcode_t opc, int target);
        return {opc, target[26:0]};
    endfunction

    // Initial data memory contents unique per word
    function automatic word_t dmem_pattern(int i);
        return {8'hd0, i[7:0], ~i[7:0], i[7:0] ^ 8'h3c};
    endfunction

    task automatic clear_models();
        int i;
        for (i = 0; i < 256; i++) begin
            imem[i] = NOP_WORD;
            dmem[i] <= dmem_pattern(i);
        end
        for (i = 0; i < 32; i++) begin
            regs[i] <= '0;
        end
        reg_log.delete();
        mem_log.delete();
        reg_want.delete();
        mem_want.delete();
        prog_len = 0;
    endtask

    task automatic begin_test();
        @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);   // Models change only while the core waits for reset
        clear_models();
        errors_at_start = errors;
    endtask

    task automatic emit(word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic end_program();
        halt_pc = prog_len;
        emit(jump_word(OP_J, prog_len));   // Self-jump
    endtask

    task automatic reg_expect(reg_addr_t r, word_t value);
        reg_want.push_back({27'b0, r, value});
    endtask

    task automatic store_expect(word_t addr, word_t value);
        mem_want.push_back({addr, value});
    endtask

    task automatic check_value(input string name, input logic [63:0] want,
                               input logic [63:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0d ns: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic reset_outputs_check();
        check_value("wren", 64'd0, {63'd0, wren});
        check_value("ctrl_write_enable", 64'd0, {63'd0, ctrl_write_enable});
        check_value("address_imem", 64'd0, {32'd0, address_imem});
    endtask

    task automatic start_core();
        int i;
        @(posedge clock);   // First edge the core sees in reset
        for (i = 1; i < RESET_CYCLES; i++) begin
            @(negedge clock);
            reset_outputs_check();
            @(posedge clock);
        end
        reset <= 1'b0;
    endtask

    task automatic run_to_halt();
        @(negedge clock);
        while (address_imem !== word_t'(halt_pc)) begin
            @(negedge clock);
        end
        repeat (DRAIN_CYCLES) @(negedge clock);   // Let the last writes retire
    endtask

    task automatic compare_logs();
        int i;
        check_value("ctrl_write_enable pulse count", reg_want.size(), reg_log.size());
        for (i = 0; i < reg_want.size() && i < reg_log.size(); i++) begin
            check_value($sformatf("ctrl_write_reg/data_write_reg write %0d", i),
                        reg_want[i], reg_log[i]);
        end
        check_value("wren pulse count", mem_want.size(), mem_log.size());
        for (i = 0; i < mem_want.size() && i < mem_log.size(); i++) begin
            check_value($sformatf("address_dmem/data write %0d", i), mem_want[i], mem_log[i]);
        end
    endtask

    task automatic finish_test(string name);
        compare_logs();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - errors_at_start);
        end
    endtask

    task automatic reset_test();
        word_t val;
        begin_test();
        val = $urandom;
        regs[1] <= val;
        emit(itype_word(OP_SW, 5'd1, 5'd0, 0));    // Store at address 0 right away
        emit(itype_word(OP_ADDI, 5'd2, 5'd0, 7));
        end_program();
        store_expect(32'd0, val);
        reg_expect(5'd2, 32'd7);
        start_core();
        @(negedge clock);
        reset_outputs_check();   // First cycle out of reset
        run_to_halt();
        finish_test("reset_state");
    endtask

    task automatic alu_chain_test();
        word_t  a, b, c, d, e;
        word_t  v10, v11, v12, v13, v14, v15, v16, v17, v18;
        shamt_t s1, s2;
        int     imm;
        begin_test();
        a = $urandom & 32'h00ff_ffff;   // Small operands keep add and sub in range
        b = $urandom & 32'h00ff_ffff;
        c = $urandom & 32'h00ff_ffff;
        d = $urandom & 32'h00ff_ffff;
        e = $urandom | 32'hff00_0000;   // Negative so sra shifts in ones
        s1 = shamt_t'(1 + $urandom % 4);
        s2 = shamt_t'(1 + $urandom % 4);
        imm = int'($urandom % 65536) - 32768;
        regs[1] <= a;
        regs[2] <= b;
        regs[3] <= c;
        regs[4] <= d;
        regs[5] <= e;
        emit(rtype_word(5'd10, 5'd1, 5'd2, ALU_ADD, 5'd0));
        emit(rtype_word(5'd11, 5'd10, 5'd3, ALU_SUB, 5'd0));
        emit(rtype_word(5'd12, 5'd11, 5'd4, ALU_AND, 5'd0));
        emit(rtype_word(5'd13, 5'd5, 5'd12, ALU_OR, 5'd0));    // Previous result on B
        emit(rtype_word(5'd14, 5'd13, 5'd0, ALU_SLL, s1));
        emit(rtype_word(5'd15, 5'd14, 5'd0, ALU_SRA, s2));
        emit(itype_word(OP_ADDI, 5'd16, 5'd15, imm));
        emit(rtype_word(5'd17, 5'd16, 5'd14, ALU_ADD, 5'd0));  // r14 via decode bypass
        emit(rtype_word(5'd18, 5'd17, 5'd16, ALU_SUB, 5'd0));  // r16 from writeback
        end_program();
        v10 = a + b;
        v11 = v10 - c;
        v12 = v11 & d;
        v13 = e | v12;
        v14 = v13 << s1;
        v15 = (v14 >> s2) | ({32{v14[31]}} << (32 - s2));   // Sign bit fills the top
        v16 = v15 + word_t'(imm);
        v17 = v16 + v14;
        v18 = v17 - v16;
        reg_expect(5'd10, v10);
        reg_expect(5'd11, v11);
        reg_expect(5'd12, v12);
        reg_expect(5'd13, v13);
        reg_expect(5'd14, v14);
        reg_expect(5'd15, v15);
        reg_expect(5'd16, v16);
        reg_expect(5'd17, v17);
        reg_expect(5'd18, v18);
        start_core();
        run_to_halt();
        finish_test("alu_chain");
    endtask

    task automatic overflow_test();
        begin_test();
        regs[1] <= 32'h7fff_fff0;
        regs[2] <= 32'h0000_0100;
        regs[3] <= 32'h8000_0010;
        emit(rtype_word(5'd5, 5'd1, 5'd2, ALU_ADD, 5'd0));    // Positive plus positive
        emit(itype_word(OP_ADDI, 5'd6, 5'd1, 32767));
        emit(rtype_word(5'd7, 5'd3, 5'd2, ALU_SUB, 5'd0));    // Negative minus positive
        emit(rtype_word(5'd8, 5'd30, 5'd2, ALU_ADD, 5'd0));   // Reads the status code
        end_program();
        reg_expect(REG_STATUS, STATUS_ADD);
        reg_expect(REG_STATUS, STATUS_ADDI);
        reg_expect(REG_STATUS, STATUS_SUB);
        reg_expect(5'd8, STATUS_SUB + 32'h100);
        start_core();
        run_to_halt();
        finish_test("overflow");
    endtask

    task automatic load_store_test();
        word_t other;
        int    v;
        begin_test();
        other = $urandom & 32'h00ff_ffff;
        v = 1 + int'($urandom % 32767);
        regs[1] <= 32'h20;   // Base address
        regs[4] <= other;
        emit(itype_word(OP_ADDI, 5'd2, 5'd0, v));
        emit(itype_word(OP_SW, 5'd2, 5'd1, 5));
        emit(itype_word(OP_LW, 5'd3, 5'd1, 5));
        emit(rtype_word(5'd5, 5'd3, 5'd4, ALU_ADD, 5'd0));   // Load-use
        emit(itype_word(OP_LW, 5'd6, 5'd1, 0));
        emit(itype_word(OP_SW, 5'd6, 5'd1, 1));              // Loaded word stored at once
        end_program();
        reg_expect(5'd2, word_t'(v));
        reg_expect(5'd3, word_t'(v));
        reg_expect(5'd5, word_t'(v) + other);
        reg_expect(5'd6, dmem_pattern(32'h20));
        store_expect(32'h25, word_t'(v));
        store_expect(32'h21, dmem_pattern(32'h20));
        start_core();
        run_to_halt();
        finish_test("load_store");
    endtask

    task automatic branch_test();
        begin_test();
        regs[1] <= 32'd5;
        regs[2] <= 32'd9;
        regs[3] <= 32'd5;
        emit(itype_word(OP_BNE, 5'd1, 5'd2, 2));      // Taken to 3
        emit(itype_word(OP_ADDI, 5'd10, 5'd0, 1));
        emit(itype_word(OP_ADDI, 5'd11, 5'd0, 2));
        emit(itype_word(OP_ADDI, 5'd12, 5'd0, 3));
        emit(itype_word(OP_BNE, 5'd1, 5'd3, 2));      // Equal so falls through
        emit(itype_word(OP_ADDI, 5'd13, 5'd0, 5));
        emit(itype_word(OP_BLT, 5'd1, 5'd2, 2));      // 5 < 9 so taken to 9
        emit(itype_word(OP_ADDI, 5'd14, 5'd0, 7));
        emit(itype_word(OP_ADDI, 5'd15, 5'd0, 8));
        emit(itype_word(OP_ADDI, 5'd16, 5'd0, 9));
        emit(itype_word(OP_BLT, 5'd2, 5'd1, 2));      // 9 < 5 fails
        emit(itype_word(OP_ADDI, 5'd17, 5'd0, 11));
        emit(itype_word(OP_BNE, 5'd17, 5'd0, 1));     // Forwarded r17 takes it to 14
        emit(itype_word(OP_ADDI, 5'd18, 5'd0, 13));
        emit(itype_word(OP_ADDI, 5'd19, 5'd0, 14));
        end_program();
        reg_expect(5'd12, 32'd3);
        reg_expect(5'd13, 32'd5);
        reg_expect(5'd16, 32'd9);
        reg_expect(5'd17, 32'd11);
        reg_expect(5'd19, 32'd14);
        start_core();
        run_to_halt();
        finish_test("branch");
    endtask

    task automatic jump_test();
        begin_test();
        emit(itype_word(OP_ADDI, 5'd1, 5'd0, 1));
        emit(jump_word(OP_J, 4));
        emit(itype_word(OP_ADDI, 5'd2, 5'd0, 2));
        emit(itype_word(OP_ADDI, 5'd3, 5'd0, 3));
        emit(jump_word(OP_JAL, 8));                   // Links 5 into r31
        emit(itype_word(OP_ADDI, 5'd4, 5'd0, 5));
        emit(NOP_WORD);
        emit(NOP_WORD);
        emit(itype_word(OP_ADDI, 5'd5, 5'd31, 1));
        end_program();
        reg_expect(5'd1, 32'd1);
        reg_expect(REG_LINK, 32'd5);
        reg_expect(5'd5, 32'd6);
        start_core();
        run_to_halt();
        finish_test("jump");
    endtask

    initial begin
        reset = 1'b1;
        void'($urandom(32'h9029));
        clear_models();
        reset_test();
        alu_chain_test();
        overflow_test();
        load_store_test();
        branch_test();
        jump_test();
        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: processor.sv
// Five-stage pipelined core
`timescale 1ns/100ps

module processor import proc_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    output word_t     address_imem,
    input  word_t     q_imem,
    output word_t     address_dmem,
    output word_t     data,
    output logic      wren,
    input  word_t     q_dmem,
    output logic      ctrl_write_enable,
    output reg_addr_t ctrl_write_reg,
    output reg_addr_t ctrl_read_reg_a,
    output reg_addr_t ctrl_read_reg_b,
    output word_t     data_write_reg,
    input  word_t     data_read_reg_a,
    input  word_t     data_read_reg_b
);

    word_t pc, pc_plus_1, next_pc, jump_target;
    word_t fd_pc, fd_instr;
    word_t dx_pc, dx_instr, dx_a, dx_b;
    word_t xm_instr, xm_result, xm_store;
    word_t mw_instr, mw_result, mw_mem;
    logic  xm_overflow, mw_overflow;

    logic stall, flush_fd, flush_dx, take_branch;
    logic sel_a_mem, sel_a_wb, sel_b_mem, sel_b_wb;
    logic sel_da_wb, sel_db_wb, sel_store_wb;

    logic      f_is_j, f_is_jal;
    reg_addr_t d_read_a, d_read_b;
    logic      d_reads_b;
    reg_addr_t x_read_a, x_read_b, x_write_reg, x_final_write_reg;
    alu_op_t   x_alu_op;
    shamt_t    x_shamt;
    logic      x_use_imm, x_is_rtype, x_is_addi, x_is_lw, x_is_bne, x_is_blt, x_is_jal;
    logic      x_overflow;
    word_t     x_result, x_store_data, branch_target;
    reg_addr_t m_write_raw, m_write_reg, m_store_src;
    logic      m_reg_write, m_is_sw;
    reg_addr_t w_write_raw, w_write_reg;
    logic      w_reg_write, w_is_lw;

    // Fetch: jumps resolve here, taken branches override from execute
    assign address_imem = pc;
    assign pc_plus_1    = pc + 1;
    assign jump_target  = {{(WORD_W-27){1'b0}}, q_imem[26:0]};
    assign next_pc = take_branch         ? branch_target :
                     (f_is_j | f_is_jal) ? jump_target   : pc_plus_1;

    instr_decoder f_dec (
        .instr(q_imem), .read_reg_a(), .read_reg_b(), .write_reg(), .alu_op(), .shamt(),
        .is_rtype(), .is_addi(), .is_lw(), .is_sw(), .is_bne(), .is_blt(),
        .is_j(f_is_j), .is_jal(f_is_jal), .reg_write(), .use_imm(), .reads_b()
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush_fd) begin
            fd_pc    <= '0;
            fd_instr <= NOP_WORD;
        end else if (!stall) begin
            fd_pc    <= pc_plus_1;
            fd_instr <= q_imem;
        end
    end

    // Decode
    instr_decoder d_dec (
        .instr(fd_instr), .read_reg_a(d_read_a), .read_reg_b(d_read_b), .write_reg(),
        .alu_op(), .shamt(), .is_rtype(), .is_addi(), .is_lw(), .is_sw(), .is_bne(),
        .is_blt(), .is_j(), .is_jal(), .reg_write(), .use_imm(), .reads_b(d_reads_b)
    );

    assign ctrl_read_reg_a = d_read_a;
    assign ctrl_read_reg_b = d_read_b;

    always_ff @(posedge clock) begin
        if (reset || flush_dx) begin
            dx_pc    <= '0;
            dx_instr <= NOP_WORD;
            dx_a     <= '0;
            dx_b     <= '0;
        end else begin
            dx_pc    <= fd_pc;
            dx_instr <= fd_instr;
            dx_a     <= sel_da_wb ? data_write_reg : data_read_reg_a;
            dx_b     <= sel_db_wb ? data_write_reg : data_read_reg_b;
        end
    end

    // Execute
    instr_decoder x_dec (
        .instr(dx_instr), .read_reg_a(x_read_a), .read_reg_b(x_read_b),
        .write_reg(x_write_reg), .alu_op(x_alu_op), .shamt(x_shamt),
        .is_rtype(x_is_rtype), .is_addi(x_is_addi), .is_lw(x_is_lw), .is_sw(),
        .is_bne(x_is_bne), .is_blt(x_is_blt), .is_j(), .is_jal(x_is_jal),
        .reg_write(), .use_imm(x_use_imm), .reads_b()
    );

    execute_stage u_execute (
        .dx_pc(dx_pc), .dx_instr(dx_instr), .dx_a(dx_a), .dx_b(dx_b),
        .m_result(xm_result), .w_data(data_write_reg),
        .alu_op(x_alu_op), .shamt(x_shamt), .use_imm(x_use_imm), .is_rtype(x_is_rtype),
        .is_addi(x_is_addi), .is_bne(x_is_bne), .is_blt(x_is_blt), .is_jal(x_is_jal),
        .write_reg(x_write_reg),
        .sel_a_mem(sel_a_mem), .sel_a_wb(sel_a_wb), .sel_b_mem(sel_b_mem), .sel_b_wb(sel_b_wb),
        .result(x_result), .store_data(x_store_data), .final_write_reg(x_final_write_reg),
        .overflow(x_overflow), .take_branch(take_branch), .branch_target(branch_target)
    );

    hazard_unit u_hazard (
        .x_is_lw(x_is_lw), .x_write_reg(x_final_write_reg),
        .d_read_a(d_read_a), .d_read_b(d_read_b), .d_reads_b(d_reads_b),
        .take_branch(take_branch),
        .stall(stall), .flush_fd(flush_fd), .flush_dx(flush_dx)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            xm_instr    <= NOP_WORD;
            xm_result   <= '0;
            xm_store    <= '0;
            xm_overflow <= 1'b0;
        end else begin
            xm_instr    <= dx_instr;
            xm_result   <= x_result;
            xm_store    <= x_store_data;
            xm_overflow <= x_overflow;
        end
    end

    // Memory
    instr_decoder m_dec (
        .instr(xm_instr), .read_reg_a(), .read_reg_b(m_store_src), .write_reg(m_write_raw),
        .alu_op(), .shamt(), .is_rtype(), .is_addi(), .is_lw(), .is_sw(m_is_sw), .is_bne(),
        .is_blt(), .is_j(), .is_jal(), .reg_write(m_reg_write), .use_imm(), .reads_b()
    );

    assign m_write_reg  = xm_overflow ? REG_STATUS : m_write_raw;
    assign address_dmem = xm_result;
    assign data         = sel_store_wb ? data_write_reg : xm_store;
    assign wren         = m_is_sw;

    always_ff @(posedge clock) begin
        if (reset) begin
            mw_instr    <= NOP_WORD;
            mw_result   <= '0;
            mw_mem      <= '0;
            mw_overflow <= 1'b0;
        end else begin
            mw_instr    <= xm_instr;
            mw_result   <= xm_result;
            mw_mem      <= q_dmem;
            mw_overflow <= xm_overflow;
        end
    end

    // Writeback
    instr_decoder w_dec (
        .instr(mw_instr), .read_reg_a(), .read_reg_b(), .write_reg(w_write_raw),
        .alu_op(), .shamt(), .is_rtype(), .is_addi(), .is_lw(w_is_lw), .is_sw(), .is_bne(),
        .is_blt(), .is_j(), .is_jal(), .reg_write(w_reg_write), .use_imm(), .reads_b()
    );

    assign w_write_reg       = mw_overflow ? REG_STATUS : w_write_raw;
    assign ctrl_write_enable = w_reg_write;
    assign ctrl_write_reg    = w_write_reg;
    assign data_write_reg    = w_is_lw ? mw_mem : mw_result;

    forwarding_unit u_forward (
        .x_read_a(x_read_a), .x_read_b(x_read_b), .d_read_a(d_read_a), .d_read_b(d_read_b),
        .m_write_reg(m_write_reg), .w_write_reg(w_write_reg), .m_store_src(m_store_src),
        .m_reg_write(m_reg_write), .w_reg_write(w_reg_write),
        .sel_a_mem(sel_a_mem), .sel_a_wb(sel_a_wb), .sel_b_mem(sel_b_mem), .sel_b_wb(sel_b_wb),
        .sel_da_wb(sel_da_wb), .sel_db_wb(sel_db_wb), .sel_store_wb(sel_store_wb)
    );

endmodule

// File: execute_stage.sv
// Execute stage datapath
`timescale 1ns/100ps

module execute_stage import proc_pkg::*; (
    input  word_t     dx_pc,      // PC+1 of the instruction
    input  word_t     dx_instr,
    input  word_t     dx_a,
    input  word_t     dx_b,
    input  word_t     m_result,
    input  word_t     w_data,
    input  alu_op_t   alu_op,
    input  shamt_t    shamt,
    input  logic      use_imm,
    input  logic      is_rtype,
    input  logic      is_addi,
    input  logic      is_bne,
    input  logic      is_blt,
    input  logic      is_jal,
    input  reg_addr_t write_reg,
    input  logic      sel_a_mem,
    input  logic      sel_a_wb,
    input  logic      sel_b_mem,
    input  logic      sel_b_wb,
    output word_t     result,
    output word_t     store_data,
    output reg_addr_t final_write_reg,
    output logic      overflow,
    output logic      take_branch,
    output word_t     branch_target
);

    word_t imm;
    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_result;
    word_t status_code;
    logic  alu_not_equal;
    logic  alu_less_than;
    logic  alu_overflow;
    logic  is_add;
    logic  is_sub;

    assign imm = {{(WORD_W-17){dx_instr[16]}}, dx_instr[16:0]};

    // Forwarded operands
    assign op_a = sel_a_mem ? m_result :
                  sel_a_wb  ? w_data   : dx_a;
    assign op_b_reg = sel_b_mem ? m_result :
                      sel_b_wb  ? w_data   : dx_b;
    assign op_b       = use_imm ? imm : op_b_reg;
    assign store_data = op_b_reg;   // rd value for sw

    alu u_alu (
        .operand_a (op_a),
        .operand_b (op_b),
        .op        (alu_op),
        .shamt     (shamt),
        .result    (alu_result),
        .not_equal (alu_not_equal),
        .less_than (alu_less_than),
        .overflow  (alu_overflow)
    );

    // Only arithmetic instructions report overflow, not address or compare math
    assign is_add   = is_rtype && (alu_op == ALU_ADD);
    assign is_sub   = is_rtype && (alu_op == ALU_SUB);
    assign overflow = alu_overflow && (is_add || is_addi || is_sub);

    assign status_code = is_sub  ? STATUS_SUB  :
                         is_addi ? STATUS_ADDI : STATUS_ADD;

    assign result = is_jal   ? dx_pc       :
                    overflow ? status_code : alu_result;
    assign final_write_reg = overflow ? REG_STATUS : write_reg;

    // blt is taken when rd < rs, i.e. A > B
    assign take_branch = (is_bne && alu_not_equal) ||
                         (is_blt && alu_not_equal && !alu_less_than);
    assign branch_target = dx_pc + imm;

endmodule

// File: hazard_unit.sv
// Stall and flush control
`timescale 1ns/100ps

module hazard_unit import proc_pkg::*; (
    input  logic      x_is_lw,
    input  reg_addr_t x_write_reg,
    input  reg_addr_t d_read_a,
    input  reg_addr_t d_read_b,
    input  logic      d_reads_b,
    input  logic      take_branch,
    output logic      stall,      // Holds PC and F/D
    output logic      flush_fd,
    output logic      flush_dx
);

    logic load_target_live;
    logic a_depends;
    logic b_depends;

    assign load_target_live = x_is_lw && (x_write_reg != '0);
    assign a_depends        = (d_read_a == x_write_reg);
    assign b_depends        = d_reads_b && (d_read_b == x_write_reg);

    // Loaded word is only ready once the lw reaches writeback
    assign stall = load_target_live && (a_depends || b_depends);

    // Taken branch kills the two younger instructions
    assign flush_fd = take_branch;
    assign flush_dx = take_branch || stall;  // Bubble behind a stalled decode

endmodule

// File: forwarding_unit.sv
// Operand forwarding selects
`timescale 1ns/100ps

module forwarding_unit import proc_pkg::*; (
    input  reg_addr_t x_read_a,
    input  reg_addr_t x_read_b,
    input  reg_addr_t d_read_a,
    input  reg_addr_t d_read_b,
    input  reg_addr_t m_write_reg,  // Already redirected to $30 on overflow
    input  reg_addr_t w_write_reg,  // Same for writeback
    input  reg_addr_t m_store_src,
    input  logic      m_reg_write,
    input  logic      w_reg_write,
    output logic      sel_a_mem,
    output logic      sel_a_wb,
    output logic      sel_b_mem,
    output logic      sel_b_wb,
    output logic      sel_da_wb,
    output logic      sel_db_wb,
    output logic      sel_store_wb
);

    logic a_hits_mem, a_hits_wb;
    logic b_hits_mem, b_hits_wb;

    assign a_hits_mem = m_reg_write && (m_write_reg == x_read_a);
    assign a_hits_wb  = w_reg_write && (w_write_reg == x_read_a);
    assign b_hits_mem = m_reg_write && (m_write_reg == x_read_b);
    assign b_hits_wb  = w_reg_write && (w_write_reg == x_read_b);

    // The younger write in memory holds the newer value
    assign sel_a_mem = a_hits_mem;
    assign sel_a_wb  = a_hits_wb && !a_hits_mem;
    assign sel_b_mem = b_hits_mem;
    assign sel_b_wb  = b_hits_wb && !b_hits_mem;

    // Register file is read in the same cycle that writeback writes it
    assign sel_da_wb = w_reg_write && (w_write_reg == d_read_a);
    assign sel_db_wb = w_reg_write && (w_write_reg == d_read_b);

    // sw data produced by the instruction one ahead, e.g. a lw
    assign sel_store_wb = w_reg_write && (w_write_reg == m_store_src);

endmodule

// File: alu.sv
// Integer ALU
`timescale 1ns/100ps

module alu import proc_pkg::*; (
    input  word_t   operand_a,
    input  word_t   operand_b,
    input  alu_op_t op,
    input  shamt_t  shamt,
    output word_t   result,
    output logic    not_equal,
    output logic    less_than,
    output logic    overflow
);

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = operand_a + operand_b;
    assign diff = operand_a - operand_b;

    // Signed overflow: operand signs versus result sign
    assign add_ovf = (operand_a[WORD_W-1] == operand_b[WORD_W-1]) &&
                     (sum[WORD_W-1] != operand_a[WORD_W-1]);
    assign sub_ovf = (operand_a[WORD_W-1] != operand_b[WORD_W-1]) &&
                     (diff[WORD_W-1] != operand_a[WORD_W-1]);

    // Compare flags come from the subtractor
    assign not_equal = |diff;
    assign less_than = diff[WORD_W-1] ^ sub_ovf;  // Sign corrected for overflow

    always_comb begin
        case (op)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_SLL: result = operand_a << shamt;
            ALU_SRA: result = word_t'($signed(operand_a) >>> shamt);
            default: result = '0;
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD: overflow = add_ovf;
            ALU_SUB: overflow = sub_ovf;
            default: overflow = 1'b0;   // Logic and shifts never overflow
        endcase
    end

endmodule

// File: instr_decoder.sv
// Instruction decoder
`timescale 1ns/100ps

module instr_decoder import proc_pkg::*; (
    input  word_t     instr,
    output reg_addr_t read_reg_a,
    output reg_addr_t read_reg_b,
    output reg_addr_t write_reg,
    output alu_op_t   alu_op,
    output shamt_t    shamt,
    output logic      is_rtype,
    output logic      is_addi,
    output logic      is_lw,
    output logic      is_sw,
    output logic      is_bne,
    output logic      is_blt,
    output logic      is_j,
    output logic      is_jal,
    output logic      reg_write,
    output logic      use_imm,
    output logic      reads_b
);

    opcode_t   opcode;
    reg_addr_t rd, rs, rt;
    logic      writes_result;
    logic      rd_as_b;

    assign opcode = instr[31:27];
    assign rd     = instr[26:22];
    assign rs     = instr[21:17];
    assign rt     = instr[16:12];
    assign shamt  = instr[11:7];

    assign is_rtype = (opcode == OP_RTYPE);
    assign is_addi  = (opcode == OP_ADDI);
    assign is_lw    = (opcode == OP_LW);
    assign is_sw    = (opcode == OP_SW);
    assign is_bne   = (opcode == OP_BNE);
    assign is_blt   = (opcode == OP_BLT);
    assign is_j     = (opcode == OP_J);
    assign is_jal   = (opcode == OP_JAL);

    // Stores and branches compare or store rd, so it goes on port B
    assign rd_as_b    = is_sw | is_bne | is_blt;
    assign read_reg_a = rs;
    assign read_reg_b = rd_as_b ? rd : rt;
    assign write_reg  = is_jal ? REG_LINK : rd;

    assign writes_result = is_rtype | is_addi | is_lw | is_jal;
    assign reg_write     = writes_result & (write_reg != '0);  // $0 is never written

    assign alu_op  = is_rtype ? instr[6:2] :
                     (is_bne | is_blt) ? ALU_SUB : ALU_ADD;
    assign use_imm = is_addi | is_lw | is_sw;

    // B feeds the ALU; sw data is picked up later by store forwarding
    assign reads_b = is_rtype | is_bne | is_blt;

endmodule

// File: proc_pkg.sv
// Processor core package
package proc_pkg;

    localparam int WORD_W = 32;
    localparam int REG_W  = 5;
    localparam int CODE_W = 5;  // Opcode, ALU-op and shift fields

    typedef logic [WORD_W-1:0] word_t;      // Data word, PC and instruction
    typedef logic [REG_W-1:0]  reg_addr_t;
    typedef logic [CODE_W-1:0] opcode_t;
    typedef logic [CODE_W-1:0] alu_op_t;
    typedef logic [CODE_W-1:0] shamt_t;

    // Opcodes
    localparam opcode_t OP_RTYPE = 5'd0;
    localparam opcode_t OP_J     = 5'd1;
    localparam opcode_t OP_BNE   = 5'd2;
    localparam opcode_t OP_JAL   = 5'd3;
    localparam opcode_t OP_ADDI  = 5'd5;
    localparam opcode_t OP_BLT   = 5'd6;
    localparam opcode_t OP_SW    = 5'd7;
    localparam opcode_t OP_LW    = 5'd8;

    // ALU operations, also the R-type function field
    localparam alu_op_t ALU_ADD = 5'd0;
    localparam alu_op_t ALU_SUB = 5'd1;
    localparam alu_op_t ALU_AND = 5'd2;
    localparam alu_op_t ALU_OR  = 5'd3;
    localparam alu_op_t ALU_SLL = 5'd4;
    localparam alu_op_t ALU_SRA = 5'd5;

    localparam reg_addr_t REG_STATUS = 5'd30;  // Overflow status lands here
    localparam reg_addr_t REG_LINK   = 5'd31;  // jal return address

    // Status codes written on overflow
    localparam word_t STATUS_ADD  = 32'd1;
    localparam word_t STATUS_ADDI = 32'd2;
    localparam word_t STATUS_SUB  = 32'd3;

    // All-zero word decodes as add $0, $0, $0 and writes nothing
    localparam word_t NOP_WORD = '0;

endpackage
